/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lcd_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= All tests passed

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(wildcard src/*.sv verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
src/lcd_pkg.sv
src/lcd_msg_rom.sv
src/lcd_init_seq.sv
src/lcd_bus_cycle.sv
src/lcd_render_ctrl.sv
src/lcd_top.sv
verif/lcd_bus_monitor.sv
verif/tb_lcd_top.sv

/* src/lcd_bus_cycle.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_cycle (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic [7:0] i_word,
    input  logic       i_rs,
    input  logic       i_long,
    output logic [7:0] o_lcd_data,
    output logic       o_lcd_en,
    output logic       o_lcd_rs,
    output logic       o_lcd_rw,
    output logic       o_done
);

    logic [1:0] phase_r;
    logic [7:0] cnt_r;      // wide enough for the clear wait
    logic       en_r;
    logic       done_r;
    logic [7:0] data_r;
    logic       rs_r;
    logic       long_r;
    logic       accept;

    assign accept = (phase_r == lcd_pkg::LCD_PH_IDLE) && i_start;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            phase_r <= lcd_pkg::LCD_PH_IDLE;
            cnt_r   <= 8'd0;
            en_r    <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            case (phase_r)
                lcd_pkg::LCD_PH_IDLE: begin
                    if (i_start) begin
                        phase_r <= lcd_pkg::LCD_PH_SETUP;
                        cnt_r   <= 8'(lcd_pkg::LCD_SETUP_CYCLES - 1);
                    end
                end
                lcd_pkg::LCD_PH_SETUP: begin
                    if (cnt_r == 8'd0) begin
                        phase_r <= lcd_pkg::LCD_PH_ENABLE;
                        en_r    <= 1'b1;
                        cnt_r   <= 8'(lcd_pkg::LCD_EN_HIGH_CYCLES - 1);
                    end else begin
                        cnt_r <= cnt_r - 8'd1;
                    end
                end
                lcd_pkg::LCD_PH_ENABLE: begin
                    if (cnt_r == 8'd0) begin
                        phase_r <= lcd_pkg::LCD_PH_EXEC;
                        en_r    <= 1'b0;   // LCD latches on this falling edge
                        cnt_r   <= long_r ? 8'(lcd_pkg::LCD_CLEAR_CYCLES - 1) :
                                            8'(lcd_pkg::LCD_EXEC_CYCLES - 1);
                    end else begin
                        cnt_r <= cnt_r - 8'd1;
                    end
                end
                default: begin
                    if (cnt_r == 8'd0) begin
                        phase_r <= lcd_pkg::LCD_PH_IDLE;
                        done_r  <= 1'b1;
                    end else begin
                        cnt_r <= cnt_r - 8'd1;
                    end
                end
            endcase
        end
    end

    // word held on the pins until the next start
    always_ff @(posedge i_clk) begin
        if (accept) begin
            data_r <= i_word;
            rs_r   <= i_rs;
            long_r <= i_long;
        end
    end

    assign o_lcd_data = data_r;
    assign o_lcd_en   = en_r;
    assign o_lcd_rs   = rs_r;
    assign o_lcd_rw   = 1'b0;  // write only
    assign o_done     = done_r;

endmodule

`default_nettype wire

/* src/lcd_init_seq.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_init_seq (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_done,
    output logic       o_req,
    output logic [7:0] o_word,
    output logic       o_long,
    output logic       o_init_done
);

    logic [2:0] idx_r;
    logic       finished_r;
    logic       last_word;

    assign last_word = (idx_r == 3'(lcd_pkg::LCD_INIT_COUNT - 1));

    // request stays up as long as words remain
    assign o_req       = ~finished_r;
    assign o_word      = lcd_pkg::LCD_INIT_WORDS[idx_r];
    assign o_long      = (idx_r == 3'(lcd_pkg::LCD_CLEAR_INDEX));  // clear needs the long wait
    assign o_init_done = finished_r;

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            idx_r      <= 3'd0;
            finished_r <= 1'b0;
        end else if (i_done && !finished_r) begin
            if (last_word) begin
                finished_r <= 1'b1;    // hold idx on the last word
            end else begin
                idx_r <= idx_r + 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/lcd_msg_rom.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_msg_rom (
    input  logic [2:0] i_mode,
    input  logic [4:0] i_index,
    output logic [7:0] o_char
);

    logic [2:0]       msg_sel;
    logic [0:15][7:0] line_text;   // line 1 with column 0 first

    // modes past the last message show recording
    assign msg_sel = (i_mode >= 3'(lcd_pkg::LCD_MODE_COUNT)) ?
                     3'(lcd_pkg::LCD_MODE_COUNT - 1) : i_mode;

    always_comb begin
        case (msg_sel)
            3'd0: line_text = {{3{lcd_pkg::LCD_CH_SPACE}},
                               lcd_pkg::LCD_CH_UP_I, lcd_pkg::LCD_CH_N, lcd_pkg::LCD_CH_I,
                               lcd_pkg::LCD_CH_T, lcd_pkg::LCD_CH_I, lcd_pkg::LCD_CH_A,
                               lcd_pkg::LCD_CH_L, lcd_pkg::LCD_CH_I, lcd_pkg::LCD_CH_Z,
                               lcd_pkg::LCD_CH_I, lcd_pkg::LCD_CH_N, lcd_pkg::LCD_CH_G,
                               lcd_pkg::LCD_CH_SPACE};
            3'd1: line_text = {{3{lcd_pkg::LCD_CH_SPACE}},
                               lcd_pkg::LCD_CH_UP_S, lcd_pkg::LCD_CH_T, lcd_pkg::LCD_CH_O,
                               lcd_pkg::LCD_CH_P,
                               {9{lcd_pkg::LCD_CH_SPACE}}};
            3'd2: line_text = {{3{lcd_pkg::LCD_CH_SPACE}},
                               lcd_pkg::LCD_CH_UP_P, lcd_pkg::LCD_CH_L, lcd_pkg::LCD_CH_A,
                               lcd_pkg::LCD_CH_Y, lcd_pkg::LCD_CH_SPACE,
                               lcd_pkg::LCD_CH_UP_P, lcd_pkg::LCD_CH_A, lcd_pkg::LCD_CH_U,
                               lcd_pkg::LCD_CH_S, lcd_pkg::LCD_CH_E,
                               {3{lcd_pkg::LCD_CH_SPACE}}};
            3'd3: line_text = {{3{lcd_pkg::LCD_CH_SPACE}},
                               lcd_pkg::LCD_CH_UP_R, lcd_pkg::LCD_CH_E, lcd_pkg::LCD_CH_C,
                               lcd_pkg::LCD_CH_O, lcd_pkg::LCD_CH_R, lcd_pkg::LCD_CH_D,
                               lcd_pkg::LCD_CH_SPACE,
                               lcd_pkg::LCD_CH_UP_P, lcd_pkg::LCD_CH_A, lcd_pkg::LCD_CH_U,
                               lcd_pkg::LCD_CH_S, lcd_pkg::LCD_CH_E,
                               lcd_pkg::LCD_CH_SPACE};
            3'd4: line_text = {{3{lcd_pkg::LCD_CH_SPACE}},
                               lcd_pkg::LCD_CH_UP_P, lcd_pkg::LCD_CH_L, lcd_pkg::LCD_CH_A,
                               lcd_pkg::LCD_CH_Y, lcd_pkg::LCD_CH_I, lcd_pkg::LCD_CH_N,
                               lcd_pkg::LCD_CH_G,
                               {6{lcd_pkg::LCD_CH_SPACE}}};
            3'd5: line_text = {{3{lcd_pkg::LCD_CH_SPACE}},
                               lcd_pkg::LCD_CH_UP_R, lcd_pkg::LCD_CH_E, lcd_pkg::LCD_CH_C,
                               lcd_pkg::LCD_CH_O, lcd_pkg::LCD_CH_R, lcd_pkg::LCD_CH_D,
                               lcd_pkg::LCD_CH_I, lcd_pkg::LCD_CH_N, lcd_pkg::LCD_CH_G,
                               {4{lcd_pkg::LCD_CH_SPACE}}};
            default: line_text = {16{lcd_pkg::LCD_CH_SPACE}};
        endcase
    end

    // line 2 is always blank
    assign o_char = i_index[4] ? lcd_pkg::LCD_CH_SPACE : line_text[i_index[3:0]];

endmodule

`default_nettype wire

/* src/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

    // bus timing in clock cycles
    localparam int LCD_SETUP_CYCLES   = 2;
    localparam int LCD_EN_HIGH_CYCLES = 4;
    localparam int LCD_EXEC_CYCLES    = 40;
    localparam int LCD_CLEAR_CYCLES   = 200;   // clear display is the slow one

    // power-up instruction list
    localparam int LCD_INIT_COUNT  = 5;
    localparam logic [7:0] LCD_INIT_WORDS [0:LCD_INIT_COUNT-1] = '{
        8'h38,  // 8-bit bus, 2 lines, 5x8 font
        8'h08,  // display off
        8'h01,  // clear
        8'h06,  // entry mode, increment
        8'h0C   // display on, cursor off
    };
    localparam int LCD_CLEAR_INDEX = 2;

    // message geometry
    localparam int         LCD_LINE_CHARS = 16;
    localparam logic [7:0] LCD_SET_LINE1  = 8'h80;
    localparam logic [7:0] LCD_SET_LINE2  = 8'hC0;
    localparam int         LCD_MODE_COUNT = 6;

    // bus cycle phases
    localparam logic [1:0] LCD_PH_IDLE   = 2'd0;
    localparam logic [1:0] LCD_PH_SETUP  = 2'd1;
    localparam logic [1:0] LCD_PH_ENABLE = 2'd2;
    localparam logic [1:0] LCD_PH_EXEC   = 2'd3;

    // render controller states
    localparam logic [1:0] LCD_RC_INIT   = 2'd0;
    localparam logic [1:0] LCD_RC_IDLE   = 2'd1;
    localparam logic [1:0] LCD_RC_RENDER = 2'd2;

    // CGROM character codes that the messages need
    localparam logic [7:0] LCD_CH_SPACE = 8'h20;
    localparam logic [7:0] LCD_CH_UP_I  = 8'h49;
    localparam logic [7:0] LCD_CH_UP_P  = 8'h50;
    localparam logic [7:0] LCD_CH_UP_R  = 8'h52;
    localparam logic [7:0] LCD_CH_UP_S  = 8'h53;
    localparam logic [7:0] LCD_CH_A     = 8'h61;
    localparam logic [7:0] LCD_CH_C     = 8'h63;
    localparam logic [7:0] LCD_CH_D     = 8'h64;
    localparam logic [7:0] LCD_CH_E     = 8'h65;
    localparam logic [7:0] LCD_CH_G     = 8'h67;
    localparam logic [7:0] LCD_CH_I     = 8'h69;
    localparam logic [7:0] LCD_CH_L     = 8'h6C;
    localparam logic [7:0] LCD_CH_N     = 8'h6E;
    localparam logic [7:0] LCD_CH_O     = 8'h6F;
    localparam logic [7:0] LCD_CH_P     = 8'h70;
    localparam logic [7:0] LCD_CH_R     = 8'h72;
    localparam logic [7:0] LCD_CH_S     = 8'h73;
    localparam logic [7:0] LCD_CH_T     = 8'h74;
    localparam logic [7:0] LCD_CH_U     = 8'h75;
    localparam logic [7:0] LCD_CH_Y     = 8'h79;
    localparam logic [7:0] LCD_CH_Z     = 8'h7A;

endpackage

`default_nettype wire

/* src/lcd_render_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_render_ctrl (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic [2:0] i_mode,
    input  logic       i_init_req,
    input  logic [7:0] i_init_word,
    input  logic       i_init_long,
    input  logic       i_init_done,
    input  logic       i_bus_done,
    input  logic [7:0] i_char,
    output logic       o_init_ack,
    output logic       o_bus_start,
    output logic [7:0] o_bus_word,
    output logic       o_bus_rs,
    output logic       o_bus_long,
    output logic [2:0] o_rom_mode,
    output logic [4:0] o_rom_index,
    output logic       o_init_finish,
    output logic       o_render_finish
);

    logic [1:0] state_r;
    logic       start_d_r;
    logic       busy_r;         // bus transaction in flight
    logic       bus_start_r;
    logic [5:0] step_r;         // 0..33 over one render
    logic       render_finish_r;
    logic [2:0] mode_r;
    logic [7:0] bus_word_r;
    logic       bus_rs_r;
    logic       bus_long_r;
    logic       start_edge;
    logic       issue;
    logic [7:0] next_word;
    logic       next_rs;
    logic       next_long;

    assign start_edge = (state_r == lcd_pkg::LCD_RC_IDLE) && i_start && !start_d_r;
    assign issue      = !busy_r &&
                        (((state_r == lcd_pkg::LCD_RC_INIT) && i_init_req && !i_init_done) ||
                         (state_r == lcd_pkg::LCD_RC_RENDER));

    always_comb begin
        next_word = i_char;
        next_rs   = 1'b1;
        next_long = 1'b0;
        if (state_r == lcd_pkg::LCD_RC_INIT) begin
            next_word = i_init_word;
            next_rs   = 1'b0;
            next_long = i_init_long;
        end else if (step_r == 6'd0) begin
            next_word = lcd_pkg::LCD_SET_LINE1;
            next_rs   = 1'b0;
        end else if (step_r == 6'(lcd_pkg::LCD_LINE_CHARS + 1)) begin
            next_word = lcd_pkg::LCD_SET_LINE2;
            next_rs   = 1'b0;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst_n) begin
        if (i_rst_n) begin
            state_r         <= lcd_pkg::LCD_RC_INIT;
            start_d_r       <= 1'b0;
            busy_r          <= 1'b0;
            bus_start_r     <= 1'b0;
            step_r          <= 6'd0;
            render_finish_r <= 1'b0;
        end else begin
            start_d_r   <= i_start;
            bus_start_r <= issue;
            if (issue) begin
                busy_r <= 1'b1;
            end else if (i_bus_done) begin
                busy_r <= 1'b0;
            end
            case (state_r)
                lcd_pkg::LCD_RC_INIT: begin
                    if (i_init_done) begin
                        state_r <= lcd_pkg::LCD_RC_IDLE;
                    end
                end
                lcd_pkg::LCD_RC_IDLE: begin
                    if (start_edge) begin
                        state_r         <= lcd_pkg::LCD_RC_RENDER;
                        step_r          <= 6'd0;
                        render_finish_r <= 1'b0;
                    end
                end
                default: begin
                    if (i_bus_done) begin
                        if (step_r == 6'(2 * lcd_pkg::LCD_LINE_CHARS + 1)) begin
                            state_r         <= lcd_pkg::LCD_RC_IDLE;
                            render_finish_r <= 1'b1;
                        end else begin
                            step_r <= step_r + 6'd1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (start_edge) begin
            mode_r <= i_mode;
        end
        if (issue) begin
            bus_word_r <= next_word;
            bus_rs_r   <= next_rs;
            bus_long_r <= next_long;
        end
    end

    // skip the address steps when counting characters
    assign o_rom_index = (step_r > 6'(lcd_pkg::LCD_LINE_CHARS + 1)) ? 5'(step_r - 6'd2) :
                                                                       5'(step_r - 6'd1);
    assign o_rom_mode      = mode_r;
    assign o_init_ack      = i_bus_done && (state_r == lcd_pkg::LCD_RC_INIT);
    assign o_bus_start     = bus_start_r;
    assign o_bus_word      = bus_word_r;
    assign o_bus_rs        = bus_rs_r;
    assign o_bus_long      = bus_long_r;
    assign o_init_finish   = (state_r != lcd_pkg::LCD_RC_INIT);
    assign o_render_finish = render_finish_r;

endmodule

`default_nettype wire

/* src/lcd_top.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_top (
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_start,
    input  logic [2:0] i_mode,
    output logic [7:0] o_lcd_data,
    output logic       o_lcd_en,
    output logic       o_lcd_rs,
    output logic       o_lcd_rw,
    output logic       o_init_finish,
    output logic       o_render_finish
);

    logic       init_req;
    logic [7:0] init_word;
    logic       init_long;
    logic       init_done;
    logic       init_ack;
    logic       bus_start;
    logic [7:0] bus_word;
    logic       bus_rs;
    logic       bus_long;
    logic       bus_done;
    logic [2:0] rom_mode;
    logic [4:0] rom_index;
    logic [7:0] rom_char;

    lcd_init_seq u_init (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_done      (init_ack),
        .o_req       (init_req),
        .o_word      (init_word),
        .o_long      (init_long),
        .o_init_done (init_done)
    );

    lcd_render_ctrl u_ctrl (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start         (i_start),
        .i_mode          (i_mode),
        .i_init_req      (init_req),
        .i_init_word     (init_word),
        .i_init_long     (init_long),
        .i_init_done     (init_done),
        .i_bus_done      (bus_done),
        .i_char          (rom_char),
        .o_init_ack      (init_ack),
        .o_bus_start     (bus_start),
        .o_bus_word      (bus_word),
        .o_bus_rs        (bus_rs),
        .o_bus_long      (bus_long),
        .o_rom_mode      (rom_mode),
        .o_rom_index     (rom_index),
        .o_init_finish   (o_init_finish),
        .o_render_finish (o_render_finish)
    );

    lcd_msg_rom u_rom (
        .i_mode  (rom_mode),
        .i_index (rom_index),
        .o_char  (rom_char)
    );

    lcd_bus_cycle u_bus (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (bus_start),
        .i_word     (bus_word),
        .i_rs       (bus_rs),
        .i_long     (bus_long),
        .o_lcd_data (o_lcd_data),
        .o_lcd_en   (o_lcd_en),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_rw   (o_lcd_rw),
        .o_done     (bus_done)
    );

endmodule

`default_nettype wire

/* verif/lcd_bus_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module lcd_bus_monitor (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic [7:0]   i_lcd_data,
    input  logic         i_lcd_en,
    input  logic         i_lcd_rs,
    input  logic         i_lcd_rw,
    input  logic         i_exp_valid,
    input  logic [8:0]   i_exp_word,     // {rs, data}
    input  logic [127:0] i_test_name,
    output logic [31:0]  o_txn_count,
    output logic [31:0]  o_err_count
);

    logic       en_d;
    logic [7:0] prev_data;
    logic       prev_rs;
    logic [7:0] hold_data;
    logic       hold_rs;
    int         en_cnt;

    always @(posedge i_clk or posedge i_rst_n) begin : watch
        int n_err;
        n_err = 0;
        if (i_rst_n) begin
            en_d        <= 1'b0;
            en_cnt      <= 0;
            o_txn_count <= 32'd0;
            o_err_count <= 32'd0;
        end else begin
            if (i_lcd_en === 1'b1) begin
                if (i_lcd_rw !== 1'b0) begin
                    $display("[ERROR] %s RW: expected 0 actual %b", i_test_name, i_lcd_rw);
                    n_err++;
                end
                if (!en_d) begin
                    en_cnt    <= 1;
                    hold_data <= i_lcd_data;
                    hold_rs   <= i_lcd_rs;
                    // word must already sit on the pins before EN rises
                    if ({prev_rs, prev_data} !== {i_lcd_rs, i_lcd_data}) begin
                        $display("[ERROR] %s setup word: expected %h actual %h",
                                 i_test_name, {i_lcd_rs, i_lcd_data}, {prev_rs, prev_data});
                        n_err++;
                    end
                end else begin
                    en_cnt <= en_cnt + 1;
                    if ({hold_rs, hold_data} !== {i_lcd_rs, i_lcd_data}) begin
                        $display("[ERROR] %s word while EN high: expected %h actual %h",
                                 i_test_name, {hold_rs, hold_data}, {i_lcd_rs, i_lcd_data});
                        n_err++;
                    end
                end
            end else if (en_d) begin
                // falling EN closes the transaction
                o_txn_count <= o_txn_count + 32'd1;
                if (en_cnt != lcd_pkg::LCD_EN_HIGH_CYCLES) begin
                    $display("[ERROR] %s EN width: expected %0d actual %0d",
                             i_test_name, lcd_pkg::LCD_EN_HIGH_CYCLES, en_cnt);
                    n_err++;
                end
                if (!i_exp_valid) begin
                    $display("unexpected bus transaction %h during %s, none was due",
                             {hold_rs, hold_data}, i_test_name);
                    n_err++;
                end else if ({hold_rs, hold_data} !== i_exp_word) begin
                    $display("[ERROR] %s transaction %0d: expected %h actual %h",
                             i_test_name, o_txn_count, i_exp_word, {hold_rs, hold_data});
                    n_err++;
                end
            end
            en_d        <= (i_lcd_en === 1'b1);
            prev_data   <= i_lcd_data;
            prev_rs     <= i_lcd_rs;
            o_err_count <= o_err_count + 32'(n_err);
        end
    end

endmodule

`default_nettype wire

/* verif/lcd_golden.txt */
// init words first, then per render one mode entry and 34 bus entries
// each entry is {rs, data}: 0xx is an instruction, 1xx a character
038 008 001 006 00C
000 080 120 120 120 149 16E 169 174 169 161 16C 169 17A 169 16E 167 120
0C0 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120
001 080 120 120 120 153 174 16F 170 120 120 120 120 120 120 120 120 120
0C0 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120
002 080 120 120 120 150 16C 161 179 120 150 161 175 173 165 120 120 120
0C0 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120
003 080 120 120 120 152 165 163 16F 172 164 120 150 161 175 173 165 120
0C0 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120
004 080 120 120 120 150 16C 161 179 169 16E 167 120 120 120 120 120 120
0C0 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120
005 080 120 120 120 152 165 163 16F 172 164 169 16E 167 120 120 120 120
0C0 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120
// mode 7 falls back to the recording text
007 080 120 120 120 152 165 163 16F 172 164 169 16E 167 120 120 120 120
0C0 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120 120

/* verif/tb_lcd_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_lcd_top;

    localparam int PER_RENDER     = 2 * lcd_pkg::LCD_LINE_CHARS + 2;
    localparam int NUM_RENDERS    = 7;
    localparam int GOLDEN_DEPTH   = lcd_pkg::LCD_INIT_COUNT + NUM_RENDERS * (PER_RENDER + 1);
    localparam int TOTAL_TXNS     = lcd_pkg::LCD_INIT_COUNT + NUM_RENDERS * PER_RENDER;
    localparam int INIT_TIMEOUT   = 2000;
    localparam int RENDER_TIMEOUT = 4000;

    logic [8:0]   golden [0:GOLDEN_DEPTH-1];
    logic         clk = 1'b0;
    logic         rst_n;
    logic         start;
    logic [2:0]   mode;
    logic [7:0]   lcd_data;
    logic         lcd_en;
    logic         lcd_rs;
    logic         lcd_rw;
    logic         init_finish;
    logic         render_finish;
    logic [127:0] test_name;
    logic         exp_valid;
    logic [8:0]   exp_word;
    logic [31:0]  txn_count;
    logic [31:0]  mon_errs;
    int           seed;
    int           tb_errs;
    int           tests_run;
    int           tests_failed;
    int           errs_at_start;
    bit           run_ok;

    always #5 clk = ~clk;

    lcd_top i_dut (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_start         (start),
        .i_mode          (mode),
        .o_lcd_data      (lcd_data),
        .o_lcd_en        (lcd_en),
        .o_lcd_rs        (lcd_rs),
        .o_lcd_rw        (lcd_rw),
        .o_init_finish   (init_finish),
        .o_render_finish (render_finish)
    );

    lcd_bus_monitor u_mon (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_lcd_data  (lcd_data),
        .i_lcd_en    (lcd_en),
        .i_lcd_rs    (lcd_rs),
        .i_lcd_rw    (lcd_rw),
        .i_exp_valid (exp_valid),
        .i_exp_word  (exp_word),
        .i_test_name (test_name),
        .o_txn_count (txn_count),
        .o_err_count (mon_errs)
    );

    // golden file holds the init words and then per render a mode entry and 34 bus words
    function automatic int golden_index(input int n);
        int k;
        if (n < lcd_pkg::LCD_INIT_COUNT) begin
            return n;
        end
        k = n - lcd_pkg::LCD_INIT_COUNT;
        return lcd_pkg::LCD_INIT_COUNT + (k / PER_RENDER) * (PER_RENDER + 1) + 1 +
               (k % PER_RENDER);
    endfunction

    assign exp_valid = (txn_count < TOTAL_TXNS);
    assign exp_word  = exp_valid ? golden[golden_index(int'(txn_count))] : 9'h000;

    task automatic begin_test(input logic [127:0] name);
        test_name     = name;
        errs_at_start = tb_errs + int'(mon_errs);
    endtask

    task automatic end_test();
        int n;
        n = tb_errs + int'(mon_errs) - errs_at_start;
        tests_run++;
        if (n == 0) begin
            $display("test %s: PASS", test_name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", test_name, n);
        end
    endtask

    task automatic check_equal(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("[ERROR] %s %s: expected %0d actual %0d", test_name, what, exp, act);
            tb_errs++;
        end
    endtask

    task automatic wait_init_finish(output bit ok);
        int i;
        i = 0;
        while (init_finish !== 1'b1 && i < INIT_TIMEOUT) begin
            @(negedge clk);
            i++;
        end
        ok = (init_finish === 1'b1);
        if (!ok) begin
            $display("timeout: init did not finish within %0d cycles", INIT_TIMEOUT);
            tb_errs++;
        end
    endtask

    task automatic wait_render_level(input logic level, output bit ok);
        int i;
        i = 0;
        while (render_finish !== level && i < RENDER_TIMEOUT) begin
            @(negedge clk);
            i++;
        end
        ok = (render_finish === level);
        if (!ok) begin
            $display("timeout: render finish flag never went to %b", level);
            tb_errs++;
        end
    endtask

    task automatic wait_txn_count(input int n, output bit ok);
        int i;
        i = 0;
        while (int'(txn_count) < n && i < RENDER_TIMEOUT) begin
            @(negedge clk);
            i++;
        end
        ok = (int'(txn_count) >= n);
        if (!ok) begin
            $display("timeout: only %0d of %0d bus transactions seen", txn_count, n);
            tb_errs++;
        end
    endtask

    task automatic run_init(output bit ok);
        begin_test("init_sequence   ");
        repeat (20) @(negedge clk);
        mode  = 3'd3;
        start = 1'b1;   // init still busy so no render
        @(negedge clk);
        start = 1'b0;
        wait_init_finish(ok);
        if (ok) begin
            check_equal("init transactions", lcd_pkg::LCD_INIT_COUNT, int'(txn_count));
            check_equal("render finish after init", 0, int'(render_finish));
        end
        end_test();
    endtask

    task automatic run_render(input int t, output bit ok);
        int         base;
        int         txn_base;
        int         hold;
        logic [2:0] m;
        base     = lcd_pkg::LCD_INIT_COUNT + t * (PER_RENDER + 1);
        txn_base = lcd_pkg::LCD_INIT_COUNT + t * PER_RENDER;
        m        = golden[base][2:0];
        hold     = 1 + int'({$random(seed)} % 8);
        begin_test({"render_mode_", 8'h30 + {5'd0, m}, "   "});
        repeat (3) @(negedge clk);
        mode  = m;
        start = 1'b1;
        @(negedge clk);
        wait_render_level(1'b0, ok);
        if (!ok) begin
            end_test();
            return;
        end
        repeat (hold - 1) @(negedge clk);   // long start is still one edge
        start = 1'b0;
        mode  = ~m;    // latched only at the edge
        wait_txn_count(txn_base + PER_RENDER / 2, ok);
        if (ok) begin
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            wait_render_level(1'b1, ok);
        end
        if (ok) begin
            check_equal("render transactions", txn_base + PER_RENDER, int'(txn_count));
        end
        end_test();
    endtask

    task automatic run_quiet();
        begin_test("quiet_after_runs");
        repeat (300) @(negedge clk);
        check_equal("total transactions", TOTAL_TXNS, int'(txn_count));
        check_equal("render finish level", 1, int'(render_finish));
        check_equal("init finish level", 1, int'(init_finish));
        end_test();
    endtask

    initial begin
        rst_n         = 1'b1;
        start         = 1'b0;
        mode          = 3'd0;
        seed          = 32'hf3fa0b31;
        tb_errs       = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errs_at_start = 0;
        test_name     = "reset           ";
        run_ok        = 1'b1;
        $readmemh("verif/lcd_golden.txt", golden);
        if ($isunknown(golden[GOLDEN_DEPTH-1])) begin
            $display("golden file verif/lcd_golden.txt is missing or too short");
            tb_errs++;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b0;
        run_init(run_ok);
        for (int t = 0; t < NUM_RENDERS && run_ok; t++) begin
            run_render(t, run_ok);
        end
        if (run_ok) begin
            run_quiet();
        end else begin
            $display("run stopped early after a timeout");
        end
        $display("tests run %0d, failed %0d, errors %0d",
                 tests_run, tests_failed, tb_errs + int'(mon_errs));
        if (run_ok && tests_failed == 0 && tb_errs + int'(mon_errs) == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
